// File: dv/square2_cases.txt
# W addr data | R addr expected | F freq duty | L count   (W R F fields hex)
# E count volume | C expected ch_on | D writes NR22 with the DAC off   (E L C decimal)
W 0 85
R 0 BF
W 1 A3
R 1 A3
W 2 5A
R 2 FF
W 3 41
R 3 FF
W 3 05
R 3 BF
W 1 F0
F 7C0 0
F 7E0 1
F 7F0 2
F 7F0 3
W 0 3A
W 3 C7
L 5
C 1
L 1
C 0
W 1 DA
F 7F0 3
E 2 14
E 3 15
E 4 15
W 1 32
F 7F0 3
E 2 2
E 4 0
D
C 0
F 7F0 1
C 0

// File: files.f
src/sq2_pkg.sv
src/ch2_regs.sv
src/ch2_freq_timer.sv
src/ch2_duty_seq.sv
src/ch2_len_env.sv
src/square2_top.sv
dv/square2_properties.sv
dv/tb_square2.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f files.f --top-module tb_square2 -o sim_square2
	./obj_dir/sim_square2 2>&1 | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then exit 1; fi
	@if ! grep -q "STATUS: PASS" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: dv/tb_square2.sv
`timescale 1ns/10ps

module tb_square2;

	localparam int CLK_DIV = 1;

	logic               clk = 1'b0;
	logic               rst_n;
	logic               wr_en;
	sq2_pkg::reg_addr_t wr_addr;
	sq2_pkg::byte_t     wr_data;
	logic               rd_en;
	sq2_pkg::reg_addr_t rd_addr;
	sq2_pkg::byte_t     rd_data;
	logic               rd_valid;
	logic               len_tick;
	logic               env_tick;
	logic               ftick;
	logic               ch_on;
	sq2_pkg::sample_t   sample;

	logic [7:0]     cmd_q[$];
	int             a_q[$];
	int             b_q[$];
	int             n_cases = 0;
	sq2_pkg::byte_t nr22_shadow = '0;   // last envelope register value written

	square2_top #(.CLK_DIV(CLK_DIV)) square2_i (.*);

	bind ch2_len_env square2_props props_i (
		.clk, .rst_n, .rd_en(1'b0), .rd_valid(1'b0), .ftick(1'b0),
		.ch_on, .sample, .state
	);
	bind square2_top square2_props props_i (
		.clk, .rst_n, .rd_en, .rd_valid, .ftick,
		.ch_on, .sample, .state(sq2_pkg::ch_state_t'(ch_on))
	);

	always #10 clk = ~clk;

	task automatic stop_run(string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic check_byte(string name, sq2_pkg::byte_t exp, sq2_pkg::byte_t act);
		if (exp !== act)
			stop_run($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_sample(string name, sq2_pkg::sample_t exp, sq2_pkg::sample_t act);
		if (exp !== act)
			stop_run($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (exp !== act)
			stop_run($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_count(string name, int exp, int act);
		if (exp != act)
			stop_run($sformatf("** Error %s: expected %0d, actual %0d", name, exp, act));
	endtask

	// step 0 is the leftmost bit
	function automatic logic duty_level(int d, int s);
		logic [7:0] pat;
		case (d)
			0:       pat = 8'b00000001;
			1:       pat = 8'b10000001;
			2:       pat = 8'b10000111;
			default: pat = 8'b01111110;
		endcase
		return pat[7 - s];
	endfunction

	task automatic write_reg(int addr, int data);
		@(negedge clk);
		wr_en   = 1'b1;
		wr_addr = sq2_pkg::reg_addr_t'(addr);
		wr_data = sq2_pkg::byte_t'(data);
		if (addr == 1)
			nr22_shadow = sq2_pkg::byte_t'(data);
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	task automatic read_reg(string name, int addr, int exp);
		@(negedge clk);
		rd_en   = 1'b1;
		rd_addr = sq2_pkg::reg_addr_t'(addr);
		@(negedge clk);
		rd_en = 1'b0;
		check_bit(name, 1'b1, rd_valid);
		check_byte(name, sq2_pkg::byte_t'(exp), rd_data);
	endtask

	task automatic wait_ftick(output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > 4096)
				stop_run("ftick did not arrive within 4096 cycles");
		end while (!ftick);
	endtask

	task automatic pulse_ticks(int n, logic env);
		repeat (n) begin
			@(negedge clk);
			if (env)
				env_tick = 1'b1;
			else
				len_tick = 1'b1;
			@(negedge clk);
			env_tick = 1'b0;
			len_tick = 1'b0;
		end
	endtask

	task automatic run_freq(string name, int f, int d);
		sq2_pkg::sample_t vol;
		int gap;
		vol = (nr22_shadow[7:3] != '0) ? nr22_shadow[7:4] : 4'h0;   // dac off gives silence
		write_reg(0, d << 6);
		write_reg(2, f & 'hff);
		write_reg(3, 'h80 | (f >> 8));
		wait_ftick(gap);
		for (int k = 0; k < 8; k++) begin
			@(negedge clk);   // sample shows the step before the ftick
			check_sample(name, duty_level(d, k) ? vol : 4'h0, sample);
			if (k < 7) begin
				wait_ftick(gap);
				check_count(name, 2048 - f, gap + 1);
			end
		end
	endtask

	task automatic check_env(string name, int n, int exp);
		int gap;
		logic seen;
		seen = 1'b0;
		pulse_ticks(n, 1'b1);
		for (int k = 0; k < 8; k++) begin   // one full waveform period
			wait_ftick(gap);
			@(negedge clk);
			if (sample != '0 || exp == 0) begin
				seen = 1'b1;
				check_sample(name, sq2_pkg::sample_t'(exp), sample);
			end
		end
		if (!seen)
			stop_run($sformatf("%s: no high sample seen over eight duty steps", name));
	endtask

	initial begin
		int         fd;
		int         code;
		int         a;
		int         b;
		logic [7:0] ch;
		logic [8*256-1:0] skip;
		string      name;
		rst_n    = 1'b0;
		wr_en    = 1'b0;
		wr_addr  = '0;
		wr_data  = '0;
		rd_en    = 1'b0;
		rd_addr  = '0;
		len_tick = 1'b0;
		env_tick = 1'b0;
		fd = $fopen("dv/square2_cases.txt", "r");
		if (fd == 0)
			stop_run("cannot open dv/square2_cases.txt");
		while ($fscanf(fd, " %c", ch) == 1) begin
			a = 0;
			b = 0;
			case (ch)
				"#":         code = $fgets(skip, fd);
				"W", "R", "F": code = $fscanf(fd, "%h %h", a, b);
				"E":         code = $fscanf(fd, "%d %d", a, b);
				"L", "C":    code = $fscanf(fd, "%d", a);
				"D":         code = 0;
				default:     stop_run($sformatf("unknown command %c in cases file", ch));
			endcase
			if (ch != "#") begin
				cmd_q.push_back(ch);
				a_q.push_back(a);
				b_q.push_back(b);
			end
		end
		$fclose(fd);
		n_cases = cmd_q.size();
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < n_cases; i++) begin
			name = $sformatf("case %0d (%c)", i + 1, cmd_q[i]);
			case (cmd_q[i])
				"W": write_reg(a_q[i], b_q[i]);
				"R": read_reg(name, a_q[i], b_q[i]);
				"F": run_freq(name, a_q[i], b_q[i]);
				"L": pulse_ticks(a_q[i], 1'b0);
				"E": check_env(name, a_q[i], b_q[i]);
				"C": check_bit(name, a_q[i][0], ch_on);
				default: begin
					write_reg(1, 'h00);   // dac off with the upper five bits clear
					@(negedge clk);
					check_bit(name, 1'b0, ch_on);
				end
			endcase
		end
		$display("STATUS: PASS");
		$finish;
	end

	// watchdog sized from the number of cases
	initial begin
		wait (n_cases > 0);
		repeat (n_cases * 2048 * 10) @(posedge clk);
		$display("simulation timed out before the cases finished");
		$display("STATUS: FAIL");
		$fatal(1);
	end

endmodule

// File: dv/square2_properties.sv
`timescale 1ns/10ps

module square2_props (
	input logic               clk,
	input logic               rst_n,
	input logic               rd_en,
	input logic               rd_valid,
	input logic               ftick,
	input logic               ch_on,
	input sq2_pkg::sample_t   sample,
	input sq2_pkg::ch_state_t state
);

	a_rd_follow: assert property (@(posedge clk) disable iff (!rst_n) rd_en |=> rd_valid)
		else $error("rd_valid missing one cycle after rd_en");

	a_rd_single: assert property (@(posedge clk) disable iff (!rst_n) !rd_en |=> !rd_valid)
		else $error("rd_valid high without a read strobe");

	a_ftick_pulse: assert property (@(posedge clk) disable iff (!rst_n) ftick |=> !ftick)
		else $error("ftick high on two cycles in a row");

	// sample lags the gate by one register stage
	a_quiet_off: assert property (@(posedge clk) disable iff (!rst_n) !ch_on |=> sample == '0)
		else $error("sample nonzero while the channel is off");

	a_reset_off: assert property (@(posedge clk) !rst_n |=> state == sq2_pkg::CH_OFF)
		else $error("channel state not off after reset");

endmodule

// File: src/square2_top.sv
`timescale 1ns/10ps

module square2_top #(
	parameter int CLK_DIV = 1
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               wr_en,
	input  sq2_pkg::reg_addr_t wr_addr,
	input  sq2_pkg::byte_t     wr_data,
	input  logic               rd_en,
	input  sq2_pkg::reg_addr_t rd_addr,
	output sq2_pkg::byte_t     rd_data,
	output logic               rd_valid,
	input  logic               len_tick,   // from the frame sequencer
	input  logic               env_tick,   // from the frame sequencer
	output logic               ftick,
	output logic               ch_on,
	output sq2_pkg::sample_t   sample
);

	sq2_pkg::duty_t       duty;
	sq2_pkg::len_t        len_load;
	logic                 len_wr;
	sq2_pkg::vol_t        env_init_vol;
	logic                 env_dir;
	sq2_pkg::env_period_t env_period;
	logic                 dac_on;
	sq2_pkg::freq_t       freq;
	logic                 len_en;
	logic                 trig;
	logic                 duty_bit;

	ch2_regs regs_i (
		.clk, .rst_n, .wr_en, .wr_addr, .wr_data,
		.rd_en, .rd_addr, .rd_data, .rd_valid,
		.duty, .len_load, .len_wr,
		.env_init_vol, .env_dir, .env_period, .dac_on,
		.freq, .len_en, .trig
	);

	ch2_freq_timer #(.CLK_DIV(CLK_DIV)) timer_i (
		.clk, .rst_n, .trig, .freq, .ftick
	);

	ch2_duty_seq duty_i (
		.clk, .rst_n, .trig, .ftick, .duty, .duty_bit
	);

	ch2_len_env len_env_i (
		.clk, .rst_n, .trig, .len_tick, .env_tick,
		.len_wr, .len_load, .len_en,
		.env_init_vol, .env_dir, .env_period, .dac_on,
		.duty_bit, .ch_on, .sample
	);

endmodule

// File: src/ch2_len_env.sv
`timescale 1ns/10ps

module ch2_len_env (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 trig,
	input  logic                 len_tick,
	input  logic                 env_tick,
	input  logic                 len_wr,
	input  sq2_pkg::len_t        len_load,
	input  logic                 len_en,
	input  sq2_pkg::vol_t        env_init_vol,
	input  logic                 env_dir,
	input  sq2_pkg::env_period_t env_period,
	input  logic                 dac_on,
	input  logic                 duty_bit,
	output logic                 ch_on,
	output sq2_pkg::sample_t     sample
);

	sq2_pkg::ch_state_t   state;
	sq2_pkg::len_t        len_cnt;
	logic                 len_expired;  // count wrapped and length stopped
	sq2_pkg::vol_t        vol;
	sq2_pkg::env_period_t env_cnt;
	logic                 env_step;

	// envelope step when the period counter runs out on this tick
	assign env_step = env_tick && (env_period != '0) && (env_cnt <= 3'd1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= sq2_pkg::CH_OFF;
			len_cnt     <= '0;
			len_expired <= 1'b0;
			vol         <= '0;
			env_cnt     <= '0;
		end else begin
			if (len_wr) begin
				len_cnt     <= len_load;
				len_expired <= 1'b0;
			end else if (trig && len_expired) begin
				len_cnt     <= '0;
				len_expired <= 1'b0;
			end else if (len_tick && len_en && !len_expired) begin
				len_cnt <= len_cnt + 1'b1;
				if (len_cnt == 6'h3f)
					len_expired <= 1'b1;
			end

			if (trig) begin
				vol     <= env_init_vol;
				env_cnt <= env_period;
			end else if (env_step) begin
				env_cnt <= env_period;
				if (env_dir && vol != 4'hf)
					vol <= vol + 1'b1;
				else if (!env_dir && vol != 4'h0)
					vol <= vol - 1'b1;
			end else if (env_tick && env_period != '0) begin
				env_cnt <= env_cnt - 1'b1;
			end

			// dac power wins over trigger and length
			if (!dac_on)
				state <= sq2_pkg::CH_OFF;
			else if (trig)
				state <= sq2_pkg::CH_RUN;
			else if (len_tick && len_en && !len_expired && len_cnt == 6'h3f)
				state <= sq2_pkg::CH_OFF;
		end
	end

	assign ch_on = (state == sq2_pkg::CH_RUN);

	always_ff @(posedge clk) begin
		if (!rst_n)
			sample <= '0;
		else
			sample <= (ch_on && duty_bit) ? vol : 4'h0;
	end

endmodule

// File: src/ch2_duty_seq.sv
`timescale 1ns/10ps

module ch2_duty_seq (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           trig,
	input  logic           ftick,
	input  sq2_pkg::duty_t duty,
	output logic           duty_bit
);

	sq2_pkg::step_t step;
	sq2_pkg::byte_t pattern;   // bit n is the level at step n

	always_ff @(posedge clk) begin
		if (!rst_n)
			step <= '0;
		else if (trig)
			step <= '0;
		else if (ftick)
			step <= step + 1'b1;   // wraps after step 7
	end

	// 12.5, 25, 50 and 75 percent waveforms
	always_comb begin
		case (duty)
			2'd0:    pattern = 8'b1000_0000;
			2'd1:    pattern = 8'b1000_0001;
			2'd2:    pattern = 8'b1110_0001;
			default: pattern = 8'b0111_1110;
		endcase
	end

	assign duty_bit = pattern[step];

endmodule

// File: src/ch2_freq_timer.sv
`timescale 1ns/10ps

module ch2_freq_timer #(
	parameter int CLK_DIV = 1
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           trig,
	input  sq2_pkg::freq_t freq,
	output logic           ftick
);

	localparam int PW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

	logic [PW-1:0]  pre_cnt;   // clocks within one timer count
	logic           cnt_en;
	sq2_pkg::freq_t cnt;

	assign cnt_en = (pre_cnt == PW'(CLK_DIV - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pre_cnt <= '0;
			cnt     <= '0;
			ftick   <= 1'b0;
		end else if (trig) begin
			// restart the period from the current frequency
			pre_cnt <= '0;
			cnt     <= freq;
			ftick   <= 1'b0;
		end else if (cnt_en) begin
			pre_cnt <= '0;
			if (cnt == 11'h7ff) begin
				cnt   <= freq;    // overflow reload
				ftick <= 1'b1;
			end else begin
				cnt   <= cnt + 1'b1;
				ftick <= 1'b0;
			end
		end else begin
			pre_cnt <= pre_cnt + 1'b1;
			ftick   <= 1'b0;
		end
	end

endmodule

// File: src/ch2_regs.sv
`timescale 1ns/10ps

module ch2_regs (
	input  logic                   clk,
	input  logic                   rst_n,

	input  logic                   wr_en,
	input  sq2_pkg::reg_addr_t     wr_addr,
	input  sq2_pkg::byte_t         wr_data,

	input  logic                   rd_en,
	input  sq2_pkg::reg_addr_t     rd_addr,
	output sq2_pkg::byte_t         rd_data,
	output logic                   rd_valid,

	output sq2_pkg::duty_t         duty,
	output sq2_pkg::len_t          len_load,
	output logic                   len_wr,

	output sq2_pkg::vol_t          env_init_vol,
	output logic                   env_dir,
	output sq2_pkg::env_period_t   env_period,
	output logic                   dac_on,

	output sq2_pkg::freq_t         freq,
	output logic                   len_en,
	output logic                   trig
);

	sq2_pkg::byte_t nr22;     // envelope register read back in full
	sq2_pkg::byte_t freq_lo;  // nr23
	logic [2:0]     freq_hi;  // nr24 bits 2:0
	sq2_pkg::byte_t rd_word;

	logic wr21, wr22, wr23, wr24;

	assign wr21 = wr_en && (wr_addr == sq2_pkg::NR21_ADDR);
	assign wr22 = wr_en && (wr_addr == sq2_pkg::NR22_ADDR);
	assign wr23 = wr_en && (wr_addr == sq2_pkg::NR23_ADDR);
	assign wr24 = wr_en && (wr_addr == sq2_pkg::NR24_ADDR);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			duty     <= '0;
			len_load <= '0;
			nr22     <= '0;
			freq_lo  <= '0;
			freq_hi  <= '0;
			len_en   <= 1'b0;
			len_wr   <= 1'b0;
			trig     <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			if (wr21) begin
				duty     <= wr_data[7:6];
				len_load <= wr_data[5:0];
			end
			if (wr22)
				nr22 <= wr_data;
			if (wr23)
				freq_lo <= wr_data;
			if (wr24) begin
				len_en  <= wr_data[6];
				freq_hi <= wr_data[2:0];
			end
			len_wr   <= wr21;                  // len_load is valid alongside
			trig     <= wr24 && wr_data[7];    // trigger bit is write-only
			rd_valid <= rd_en;
		end
	end

	assign env_init_vol = nr22[7:4];
	assign env_dir      = nr22[3];
	assign env_period   = nr22[2:0];
	assign dac_on       = |nr22[7:3];      // dac powered when vol or dir set
	assign freq         = {freq_hi, freq_lo};

	// unused and write-only bits read as ones
	always_comb begin
		case (rd_addr)
			sq2_pkg::NR21_ADDR: rd_word = {duty, 6'h3f};
			sq2_pkg::NR22_ADDR: rd_word = nr22;
			sq2_pkg::NR23_ADDR: rd_word = 8'hff;
			default:            rd_word = {1'b1, len_en, 6'h3f};
		endcase
	end

	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= rd_word;
	end

endmodule

// File: src/sq2_pkg.sv
package sq2_pkg;

	// register data and select
	typedef logic [7:0] byte_t;
	typedef logic [1:0] reg_addr_t;

	// channel fields
	typedef logic [1:0]  duty_t;       // waveform duty select
	typedef logic [5:0]  len_t;        // length load and count
	typedef logic [3:0]  vol_t;        // envelope volume
	typedef logic [2:0]  env_period_t; // envelope step period
	typedef logic [10:0] freq_t;       // frequency value and timer count
	typedef logic [2:0]  step_t;       // duty step index
	typedef logic [3:0]  sample_t;     // dac input sample

	// channel register map
	localparam reg_addr_t NR21_ADDR = 2'd0; // duty and length load
	localparam reg_addr_t NR22_ADDR = 2'd1; // envelope
	localparam reg_addr_t NR23_ADDR = 2'd2; // frequency low byte
	localparam reg_addr_t NR24_ADDR = 2'd3; // trigger, length enable, freq high

	// channel gating state
	typedef enum logic {
		CH_OFF,
		CH_RUN
	} ch_state_t;

endpackage
